// File: design/grid_cfg.svh
`ifndef GRID_CFG_SVH
`define GRID_CFG_SVH

// grid shape in squares and pixels
`define GRID_COLS       8       // sequencer steps
`define GRID_ROWS       4       // instruments
`define SQUARE_SIDE     4       // pixels along one edge
`define GRID_SQUARES    32      // cols times rows
`define SQUARE_PIXELS   16      // side squared

// placement on the 160x120 plot area
`define ORIGIN_X        10      // left edge of square 0
`define ORIGIN_Y        20      // top edge of square 0
`define PITCH_X         20      // corner to corner, across
`define PITCH_Y         20      // corner to corner, down

// field widths
`define X_BITS          8
`define Y_BITS          7
`define COLOUR_BITS     3       // one bit per channel
`define COL_BITS        3       // log2 of GRID_COLS
`define ROW_BITS        2       // log2 of GRID_ROWS
`define SQUARE_BITS     5       // log2 of GRID_SQUARES
`define PIXEL_BITS      4       // log2 of SQUARE_PIXELS
`define STEP_BITS       4       // step number from the sequencer

`endif

// File: design/grid_pkg.sv
`include "grid_cfg.svh"

package grid_pkg;

	// pixel coordinates on the plot area
	typedef logic [`X_BITS-1:0] coord_x_t;
	typedef logic [`Y_BITS-1:0] coord_y_t;

	// red, green, blue from msb down
	typedef logic [`COLOUR_BITS-1:0] colour_t;

	typedef logic [`SQUARE_BITS-1:0] square_idx_t;    // square number, column major
	typedef logic [`PIXEL_BITS-1:0] pixel_idx_t;      // pixel within a square, row major

	// current step, 1 to 8 names a column, anything else names none
	typedef logic [`STEP_BITS-1:0] step_t;

	typedef logic [`GRID_COLS-1:0] pattern_t;         // bit n set means on at step n+1

	// on/off patterns for instruments 1 to 4
	typedef struct packed {
		pattern_t ins1;       // row 0
		pattern_t ins2;       // row 1
		pattern_t ins3;       // row 2
		pattern_t ins4;       // row 3
	} track_set_t;

	// scan position handed to the colour stage
	typedef struct packed {
		square_idx_t square;
		coord_x_t    x;
		coord_y_t    y;
	} scan_pos_t;

	// one plotted pixel
	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
		colour_t  colour;
	} pixel_t;

	localparam colour_t COLOUR_PLAYING = 3'b100;  // on and current
	localparam colour_t COLOUR_ACTIVE  = 3'b010;  // on, not current
	localparam colour_t COLOUR_CURSOR  = 3'b001;  // current, not on
	localparam colour_t COLOUR_IDLE    = 3'b111;  // neither

endpackage

// File: design/square_scan.sv
`timescale 1ns/1ns
`include "grid_cfg.svh"

module square_scan (
	input  logic                clk,
	input  logic                reset,
	input  logic                play,
	output grid_pkg::scan_pos_t pos
);

	grid_pkg::pixel_idx_t  pixel_cnt;      // pixel within the current square
	grid_pkg::square_idx_t square_cnt;     // square within the grid
	logic                  last_pixel;
	logic                  last_square;

	logic [`COL_BITS-1:0]  col;            // sequencer step of this square
	logic [`ROW_BITS-1:0]  row;            // instrument of this square
	grid_pkg::coord_x_t    corner_x;
	grid_pkg::coord_y_t    corner_y;
	grid_pkg::coord_x_t    offset_x;
	grid_pkg::coord_y_t    offset_y;

	assign last_pixel  = (pixel_cnt == grid_pkg::pixel_idx_t'(`SQUARE_PIXELS - 1));
	assign last_square = (square_cnt == grid_pkg::square_idx_t'(`GRID_SQUARES - 1));

	// pixel counter, one step per play cycle
	always_ff @(posedge clk) begin
		if (!reset) begin
			pixel_cnt <= '0;
		end else if (play) begin
			if (last_pixel)
				pixel_cnt <= '0;
			else
				pixel_cnt <= pixel_cnt + grid_pkg::pixel_idx_t'(1);
		end
	end

	// square counter moves on once the last pixel has gone out
	always_ff @(posedge clk) begin
		if (!reset) begin
			square_cnt <= '0;
		end else if (play && last_pixel) begin
			if (last_square)
				square_cnt <= '0;                      // back to the top left
			else
				square_cnt <= square_cnt + grid_pkg::square_idx_t'(1);
		end
	end

	// squares run down a column first, then across
	assign col = `COL_BITS'(square_cnt / `GRID_ROWS);
	assign row = `ROW_BITS'(square_cnt % `GRID_ROWS);

	// corner of the square from origin and pitch
	assign corner_x = grid_pkg::coord_x_t'(`ORIGIN_X + `PITCH_X * col);
	assign corner_y = grid_pkg::coord_y_t'(`ORIGIN_Y + `PITCH_Y * row);

	// low bits of the pixel index step across, high bits step down
	assign offset_x = grid_pkg::coord_x_t'(pixel_cnt % `SQUARE_SIDE);
	assign offset_y = grid_pkg::coord_y_t'(pixel_cnt / `SQUARE_SIDE);

	always_comb begin
		pos.square = square_cnt;
		pos.x      = corner_x + offset_x;
		pos.y      = corner_y + offset_y;
	end

endmodule

// File: design/square_colour.sv
`timescale 1ns/1ns
`include "grid_cfg.svh"

module square_colour (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 play,
	input  grid_pkg::scan_pos_t  pos,
	input  grid_pkg::track_set_t tracks,
	input  grid_pkg::step_t      timing,
	output logic                 plot,
	output grid_pkg::pixel_t     pixel
);

	logic [`COL_BITS-1:0] col;
	logic [`ROW_BITS-1:0] row;
	grid_pkg::pattern_t   pattern;        // pattern of the instrument on this row
	logic                 active;         // instrument on at this step
	logic                 current;        // this step is playing now
	grid_pkg::colour_t    colour;

	// same split as the scan, column major numbering
	assign col = `COL_BITS'(pos.square / `GRID_ROWS);
	assign row = `ROW_BITS'(pos.square % `GRID_ROWS);

	always_comb begin
		unique case (row)
			2'd0: pattern = tracks.ins1;
			2'd1: pattern = tracks.ins2;
			2'd2: pattern = tracks.ins3;
			2'd3: pattern = tracks.ins4;
		endcase
	end

	assign active = pattern[col];

	// steps count from 1, so 0 and 9 and up never match
	assign current = (timing == grid_pkg::step_t'(col + 1));

	always_comb begin
		unique case ({active, current})
			2'b11:   colour = grid_pkg::COLOUR_PLAYING;
			2'b10:   colour = grid_pkg::COLOUR_ACTIVE;
			2'b01:   colour = grid_pkg::COLOUR_CURSOR;
			default: colour = grid_pkg::COLOUR_IDLE;
		endcase
	end

	// one cycle from a play edge to the plot strobe
	always_ff @(posedge clk) begin
		if (!reset) begin
			plot  <= 1'b0;
			pixel <= '0;
		end else begin
			plot <= play;
			if (play) begin
				pixel.x      <= pos.x;
				pixel.y      <= pos.y;
				pixel.colour <= colour;
			end
		end
	end

endmodule

// File: design/step_grid_painter.sv
`timescale 1ns/1ns

module step_grid_painter (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 play,
	input  grid_pkg::step_t      timing,
	input  grid_pkg::track_set_t tracks,
	output logic                 plot,
	output grid_pkg::pixel_t     pixel
);

	grid_pkg::scan_pos_t pos;      // square and pixel address being drawn

	// walks squares and pixels while play is high
	square_scan scan_i (
		.clk   (clk),
		.reset (reset),
		.play  (play),
		.pos   (pos)
	);

	// colour lookup and output register
	square_colour colour_i (
		.clk    (clk),
		.reset  (reset),
		.play   (play),
		.pos    (pos),
		.tracks (tracks),
		.timing (timing),
		.plot   (plot),
		.pixel  (pixel)
	);

endmodule

// File: bench/step_grid_painter_sva.sv
`timescale 1ns/1ns

module step_grid_painter_sva (
	input logic             clk,
	input logic             reset,
	input logic             play,
	input logic             plot,
	input grid_pkg::pixel_t pixel
);

	// strobe is cleared by the reset edge
	plot_low_after_reset: assert property (
		@(posedge clk) !reset |=> !plot
	) else $error("plot high in the cycle after reset");

	// one cycle from sampled play to the strobe
	plot_follows_play: assert property (
		@(posedge clk) reset |=> (plot == $past(play))
	) else $error("plot does not follow play from the previous edge");

	pixel_held_when_idle: assert property (
		@(posedge clk) disable iff (!reset)
		!plot |-> $stable(pixel)
	) else $error("pixel changed while plot was low");

	// only the four square colours are ever drawn
	colour_legal: assert property (
		@(posedge clk) disable iff (!reset)
		plot |-> (pixel.colour == grid_pkg::COLOUR_PLAYING
			|| pixel.colour == grid_pkg::COLOUR_ACTIVE
			|| pixel.colour == grid_pkg::COLOUR_CURSOR
			|| pixel.colour == grid_pkg::COLOUR_IDLE)
	) else $error("plotted colour is not one of the square colours");

endmodule

// File: bench/step_grid_painter_tb.sv
`timescale 1ns/1ns
`include "grid_cfg.svh"

module step_grid_painter_tb;

	typedef struct packed {
		grid_pkg::step_t      timing;
		grid_pkg::track_set_t tracks;
		logic [15:0]          cycles;     // clock cycles spent in this segment
		logic [95:0]          colours;    // square n in bits 3n+2 down to 3n
	} segment_t;

	logic                 clk;
	logic                 reset;
	logic                 play;
	grid_pkg::step_t      timing;
	grid_pkg::track_set_t tracks;
	logic                 plot;
	grid_pkg::pixel_t     pixel;

	segment_t         segments[$];
	logic [15:0]      lfsr = 16'd92;
	int               cycle_cnt = 0;
	int               timeout_limit = 0;   // set once the trace is read
	int               model_square = 0;    // scan position the DUT should be at
	int               model_pixel = 0;
	int               passes = 0;          // full grids drawn
	grid_pkg::pixel_t held_pixel;

	step_grid_painter dut_i (
		.clk    (clk),
		.reset  (reset),
		.play   (play),
		.timing (timing),
		.tracks (tracks),
		.plot   (plot),
		.pixel  (pixel)
	);

	bind step_grid_painter step_grid_painter_sva sva_i (
		.clk   (clk),
		.reset (reset),
		.play  (play),
		.plot  (plot),
		.pixel (pixel)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (timeout_limit != 0 && cycle_cnt >= timeout_limit)
			abort_run($sformatf("timeout: run still going after %0d cycles", cycle_cnt));
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string what, input logic [95:0] got,
			input logic [95:0] expected);
		if (got !== expected)
			abort_run($sformatf("CHECK FAILED at %0t ns: %s, got %0h, expected %0h",
				$time, what, got, expected));
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		logic feedback;
		feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
		return {state[14:0], feedback};
	endfunction

	task automatic draw_play(output logic value);
		logic first;
		lfsr  = lfsr_next(lfsr);
		first = lfsr[0];
		lfsr  = lfsr_next(lfsr);
		value = first | lfsr[0];            // low one time in four
	endtask

	// colour of one square straight from the step and pattern rule
	function automatic grid_pkg::colour_t rule_colour(input segment_t seg, input int square);
		logic [`COL_BITS-1:0] col;
		logic [`ROW_BITS-1:0] row;
		grid_pkg::pattern_t   pattern;
		logic                 active;
		logic                 current;
		col = `COL_BITS'(square / `GRID_ROWS);
		row = `ROW_BITS'(square % `GRID_ROWS);
		case (row)
			2'd0:    pattern = seg.tracks.ins1;
			2'd1:    pattern = seg.tracks.ins2;
			2'd2:    pattern = seg.tracks.ins3;
			default: pattern = seg.tracks.ins4;
		endcase
		active  = pattern[col];
		current = (seg.timing == grid_pkg::step_t'(col) + grid_pkg::step_t'(1));
		if (active && current)
			return grid_pkg::COLOUR_PLAYING;
		else if (active)
			return grid_pkg::COLOUR_ACTIVE;
		else if (current)
			return grid_pkg::COLOUR_CURSOR;
		return grid_pkg::COLOUR_IDLE;
	endfunction

	function automatic logic [95:0] rule_word(input segment_t seg);
		logic [95:0] word;
		word = '0;
		for (int n = 0; n < `GRID_SQUARES; n++)
			word[3*n +: 3] = rule_colour(seg, n);
		return word;
	endfunction

	// bit 3 red, 2 green, 1 blue, 0 white
	function automatic logic [3:0] colours_present(input logic [95:0] word);
		logic [3:0]        mask;
		grid_pkg::colour_t c;
		mask = '0;
		for (int n = 0; n < `GRID_SQUARES; n++) begin
			c = word[3*n +: 3];
			if (c == grid_pkg::COLOUR_PLAYING) mask[3] = 1'b1;
			if (c == grid_pkg::COLOUR_ACTIVE)  mask[2] = 1'b1;
			if (c == grid_pkg::COLOUR_CURSOR)  mask[1] = 1'b1;
			if (c == grid_pkg::COLOUR_IDLE)    mask[0] = 1'b1;
		end
		return mask;
	endfunction

	task automatic load_trace();
		int          fd;
		int          code;
		int          cycles_total;
		string       line;
		logic [3:0]  t;
		logic [7:0]  p1, p2, p3, p4;
		int          cyc;
		logic [95:0] word;
		segment_t    seg;
		fd = $fopen("bench/grid_trace.txt", "r");
		if (fd == 0)
			abort_run("cannot open the trace file bench/grid_trace.txt");
		cycles_total = 0;
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code > 1 && line.getc(0) != 8'h23) begin   // skip blanks and # lines
				code = $sscanf(line, "%h %h %h %h %h %d %h", t, p1, p2, p3, p4, cyc, word);
				if (code != 7)
					abort_run($sformatf("trace line not understood: %s", line));
				seg.timing      = t;
				seg.tracks.ins1 = p1;
				seg.tracks.ins2 = p2;
				seg.tracks.ins3 = p3;
				seg.tracks.ins4 = p4;
				seg.cycles      = 16'(cyc);
				seg.colours     = word;
				segments.push_back(seg);
				cycles_total += cyc;
			end
		end
		$fclose(fd);
		if (segments.size() == 0)
			abort_run("the trace file holds no segments");
		timeout_limit = 2 * cycles_total + 100;
	endtask

	// outputs one edge after the inputs were driven
	task automatic check_outputs(input logic sampled_play, input segment_t seg);
		grid_pkg::pixel_t expected;
		if (sampled_play) begin
			expected.x = grid_pkg::coord_x_t'(`ORIGIN_X + `PITCH_X * (model_square / `GRID_ROWS)
				+ model_pixel % `SQUARE_SIDE);
			expected.y = grid_pkg::coord_y_t'(`ORIGIN_Y + `PITCH_Y * (model_square % `GRID_ROWS)
				+ model_pixel / `SQUARE_SIDE);
			expected.colour = seg.colours[3*model_square +: 3];
			check_value("plot strobe", 96'(plot), 96'd1);
			check_value("pixel x", 96'(pixel.x), 96'(expected.x));
			check_value("pixel y", 96'(pixel.y), 96'(expected.y));
			check_value("pixel colour", 96'(pixel.colour), 96'(expected.colour));
			held_pixel = pixel;
			if (model_pixel == `SQUARE_PIXELS - 1) begin
				model_pixel = 0;
				if (model_square == `GRID_SQUARES - 1) begin
					model_square = 0;                // wrap to the top left
					passes++;
				end else begin
					model_square++;
				end
			end else begin
				model_pixel++;
			end
		end else begin
			check_value("plot while paused", 96'(plot), 96'd0);
			check_value("pixel held while paused", 96'(pixel), 96'(held_pixel));
		end
	endtask

	initial begin
		logic       next_play;
		logic [3:0] expected_mask;
		reset      = 1'b0;
		play       = 1'b0;
		timing     = '0;
		tracks     = '0;
		held_pixel = '0;
		load_trace();
		repeat (8) @(negedge clk);
		reset = 1'b1;
		check_value("plot after reset", 96'(plot), 96'd0);
		check_value("pixel after reset", 96'(pixel), 96'd0);
		foreach (segments[s]) begin
			check_value("trace colours against the rule", segments[s].colours,
				rule_word(segments[s]));
			// steps 1 to 8 give all four colours, anything else only green and white
			if (segments[s].timing >= 4'd1 && segments[s].timing <= 4'd8)
				expected_mask = 4'b1111;
			else
				expected_mask = 4'b0101;
			check_value("colours in segment", 96'(colours_present(segments[s].colours)),
				96'(expected_mask));
			for (int c = 0; c < int'(segments[s].cycles); c++) begin
				draw_play(next_play);
				play   = next_play;
				timing = segments[s].timing;
				tracks = segments[s].tracks;
				@(negedge clk);
				check_outputs(next_play, segments[s]);
			end
		end
		check_value("grid wrapped at least once", 96'(passes > 0), 96'd1);
		$display("Verification passed");
		$finish;
	end

endmodule

// File: bench/grid_trace.txt
# step grid painter stimulus, one segment per line
# columns: timing ins1 ins2 ins3 ins4 (hex), cycles (decimal), square colours (hex)
# square n colour sits in bits 3n+2:3n of the last word, red green blue from the top
# pattern bit n set means the instrument plays at step n+1

# step 1 current, long enough for a full grid and a wrap
1 0f 33 55 00 720 FFFEBFFD7E97FFAEBAFD2324

# step 6 current
6 0f 33 55 00 200 FFFEBF261E97FFAEBAFD2E92

# no step current
0 0f 33 55 00 150 FFFEBFFD7E97FFAEBAFD2E92

# patterns swapped to their complements, still no step
9 f0 cc aa ff 150 4925D24BA5FA4975D74BF5FF

# step 3 current
3 f0 cc aa ff 300 4925D24BA5FA4978614BF5FF

# step 7 current
7 f0 cc aa ff 200 4928644BA5FA4975D74BF5FF

# back to the first patterns, step 4 current
4 0f 33 55 00 200 FFFEBFFD7E9724CEBAFD2E92

// File: step_grid_painter.f
+incdir+design
design/grid_pkg.sv
design/square_scan.sv
design/square_colour.sv
design/step_grid_painter.sv
bench/step_grid_painter_sva.sv
bench/step_grid_painter_tb.sv

// File: Makefile
# Verilator build and run of the step grid painter testbench

VERILATOR ?= verilator
TOP       ?= step_grid_painter_tb
FILELIST  ?= step_grid_painter.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Verification passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_TEXT VFLAGS"

$(BUILD_DIR)/$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)

test: $(BUILD_DIR)/$(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
